// File: Bender.yml
package:
  name: memStage

sources:
  - memStagePkg.sv
  - memIfs.sv
  - memStageReg.sv
  - memAccessUnit.sv
  - exceptionUnit.sv
  - cp0Regs.sv
  - memStageTop.sv
  - target: test
    files:
      - tbMemStage.sv

// File: cp0Regs.sv
// coprocessor 0 with Status, Cause, EPC and BadVAddr, serving MFC0/MTC0 and exception/ERET commits
`timescale 1ns/1ps

module cp0Regs (
    input  logic        clk,
    input  logic        rst,
    input  logic        memDisWr,
    input  logic [5:0]  interrupt,
    memPipeIf.sink      pipe,
    cp0ExcIf.cp0        ce,
    output logic [31:0] cp0RdData,
    output logic [31:0] cp0Epc
);
    import memStagePkg::*;

    logic        statusBev;
    logic [7:0]  statusIm;
    logic        statusExl;
    logic        statusIe;
    logic [5:0]  causeIpHw;   // IP7..2
    logic [1:0]  causeIpSw;   // IP1..0, software interrupts
    logic [4:0]  causeExcCode;
    logic [31:0] epc;
    logic [31:0] badVAddr;
    logic        mtc0Wr;
    logic        epcWr;
    logic [31:0] statusWord;
    logic [31:0] causeWord;

    // MTC0 loses to an exception taken on the same instruction
    assign mtc0Wr = pipe.valid && (pipe.op == OP_MTC0) && !memDisWr && !ce.excTake;
    assign epcWr  = mtc0Wr && (pipe.cp0Addr == CP0_EPC);

    always_ff @(posedge clk) begin
        if (rst) begin
            statusBev    <= 1'b1;
            statusIm     <= '0;
            statusExl    <= 1'b0;
            statusIe     <= 1'b0;
            causeIpHw    <= '0;
            causeIpSw    <= '0;
            causeExcCode <= '0;
            epc          <= '0;
        end else begin
            causeIpHw <= interrupt; // hardware lines sampled every cycle
            if (ce.excTake) begin
                statusExl    <= 1'b1;
                causeExcCode <= ce.excCode;
                epc          <= ce.excPc;
            end else if (ce.eretTake) begin
                statusExl <= 1'b0;
            end else if (mtc0Wr) begin
                case (pipe.cp0Addr)
                    CP0_STATUS: begin
                        statusBev <= pipe.storeData[22];
                        statusIm  <= pipe.storeData[15:8];
                        statusIe  <= pipe.storeData[0];
                    end
                    CP0_CAUSE: causeIpSw <= pipe.storeData[9:8];
                    CP0_EPC:   epc       <= pipe.storeData;
                    default:   ;
                endcase
            end
        end
    end

    // BadVAddr only on address errors, also writable
    always_ff @(posedge clk) begin
        if (ce.excTake && (ce.excCode == EXC_ADEL || ce.excCode == EXC_ADES)) begin
            badVAddr <= ce.badVAddr;
        end else if (mtc0Wr && pipe.cp0Addr == CP0_BADVADDR) begin
            badVAddr <= pipe.storeData;
        end
    end

    assign statusWord = {9'd0, statusBev, 6'd0, statusIm, 6'd0, statusExl, statusIe};
    assign causeWord  = {16'd0, causeIpHw, causeIpSw, 1'b0, causeExcCode, 2'b00};

    // MFC0 read port
    always_comb begin
        case (pipe.cp0Addr)
            CP0_BADVADDR: cp0RdData = badVAddr;
            CP0_STATUS:   cp0RdData = statusWord;
            CP0_CAUSE:    cp0RdData = causeWord;
            CP0_EPC:      cp0RdData = epc;
            default:      cp0RdData = 32'd0;
        endcase
    end

    assign ce.statusBev = statusBev;
    assign ce.statusIm  = statusIm;
    assign ce.statusExl = statusExl;
    assign ce.statusIe  = statusIe;
    assign ce.causeIp   = {causeIpHw, causeIpSw};
    assign ce.epc       = epc;
    assign cp0Epc       = epc;

    // EPC only moves on an exception entry or an explicit write
    epcStable: assert property (
        @(posedge clk) disable iff (rst)
        !(ce.excTake || epcWr) |=> $stable(epc)
    ) else $error("cp0Regs: EPC changed without excTake or MTC0");

endmodule

// File: exceptionUnit.sv
// exception prioritising for the MEM stage, drives the flush strobe, handler vector and CP0 commit
`timescale 1ns/1ps

module exceptionUnit (
    memPipeIf.sink      pipe,
    cp0ExcIf.exc        ce,
    input  logic        memDisWr,
    output logic        memRegsWr,
    output logic        excFlush,
    output logic [31:0] excVector
);
    import memStagePkg::*;

    logic     intHit;
    logic     passHit;
    logic     adelHit;
    logic     adesHit;
    logic     excHit;
    logic     eretHit;
    excCode_e code;

    // interrupts only outside a handler and with global enable
    assign intHit  = pipe.valid && ce.statusIe && !ce.statusExl
                  && |(ce.causeIp & ce.statusIm);
    assign passHit = pipe.valid && (pipe.excIn != EXC_NONE);
    assign adelHit = pipe.valid && (pipe.op == OP_LW) && (pipe.aluOut[1:0] != 2'b00);
    assign adesHit = pipe.valid && (pipe.op == OP_SW) && (pipe.aluOut[1:0] != 2'b00);

    // highest priority first
    always_comb begin
        code = EXC_NONE;
        if (intHit) begin
            code = EXC_INT;
        end else if (passHit) begin
            code = pipe.excIn;
        end else if (adelHit) begin
            code = EXC_ADEL;
        end else if (adesHit) begin
            code = EXC_ADES;
        end
    end

    assign excHit  = (code != EXC_NONE);
    assign eretHit = pipe.valid && (pipe.op == OP_ERET) && !excHit; // a faulting ERET traps

    // one strobe flushes every younger stage
    assign excFlush  = excHit || eretHit;
    assign memRegsWr = pipe.valid && pipe.regsWr && !excFlush;

    always_comb begin
        if (eretHit) begin
            excVector = ce.epc;
        end else if (ce.statusBev) begin
            excVector = VEC_BOOT;
        end else begin
            excVector = VEC_NORMAL;
        end
    end

    // commit only once the stall is released
    assign ce.excTake  = excHit && !memDisWr;
    assign ce.eretTake = eretHit && !memDisWr;
    assign ce.excCode  = code;
    assign ce.excPc    = pipe.pc;
    assign ce.badVAddr = pipe.aluOut; // only kept by CP0 for AdEL/AdES

endmodule

// File: memAccessUnit.sv
// data scratchpad with byte strobes, load extension and the writeback/forwarding result mux
`timescale 1ns/1ps

module memAccessUnit #(
    parameter int MEM_WORDS = 256
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        memDisWr,
    input  logic        excFlush,
    memPipeIf.sink      pipe,
    input  logic [31:0] cp0RdData,
    output logic [31:0] memResult
);
    import memStagePkg::*;

    localparam int IDX_W = $clog2(MEM_WORDS);

    logic [31:0]      mem [MEM_WORDS];
    logic [IDX_W-1:0] wordIdx;
    logic [3:0]       byteStrobe;
    logic [31:0]      wrData;
    logic             wrEn;
    logic [31:0]      rdWord;
    logic [7:0]       rdByte;
    logic [31:0]      loadData;

    assign wordIdx = pipe.aluOut[IDX_W+1:2]; // word address, upper bits ignored

    // byte lanes for the store
    always_comb begin
        byteStrobe = 4'b0000;
        wrData     = pipe.storeData;
        case (pipe.op)
            OP_SW: byteStrobe = 4'b1111;
            OP_SB: begin
                byteStrobe = 4'b0001 << pipe.aluOut[1:0];
                wrData     = {4{pipe.storeData[7:0]}}; // replicate into every lane
            end
            default: byteStrobe = 4'b0000;
        endcase
    end

    // no commit while stalled or when the instruction faults
    assign wrEn = pipe.valid && !memDisWr && !excFlush && (byteStrobe != 4'b0000);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (wrEn) begin
            for (int b = 0; b < 4; b++) begin
                if (byteStrobe[b]) begin
                    mem[wordIdx][8*b +: 8] <= wrData[8*b +: 8];
                end
            end
        end
    end

    // asynchronous read
    assign rdWord = mem[wordIdx];
    assign rdByte = rdWord[8*pipe.aluOut[1:0] +: 8];

    always_comb begin
        case (pipe.op)
            OP_LB:   loadData = {{24{rdByte[7]}}, rdByte}; // sign extend
            OP_LBU:  loadData = {24'd0, rdByte};
            default: loadData = rdWord;
        endcase
    end

    // result for both forwarding and writeback
    always_comb begin
        case (pipe.wbSel)
            WB_LINK: memResult = pipe.pc + 32'd8;
            WB_ALU:  memResult = pipe.aluOut;
            WB_LOAD: memResult = loadData;
            default: memResult = cp0RdData;
        endcase
    end

endmodule

// File: memIfs.sv
// interfaces for the MEM-stage instruction bundle and the CP0/exception handshake
`timescale 1ns/1ps

interface memPipeIf;
    import memStagePkg::*;

    logic        valid;
    memOp_e      op;
    logic [31:0] pc;
    logic [31:0] aluOut;    // also the data address
    logic [31:0] storeData; // rt value, also MTC0 data
    logic [4:0]  dst;
    logic        regsWr;
    wbSel_e      wbSel;
    logic [4:0]  cp0Addr;
    excCode_e    excIn;     // code passed down from execute

    modport stage (
        output valid, op, pc, aluOut, storeData, dst, regsWr, wbSel, cp0Addr, excIn
    );

    modport sink (
        input valid, op, pc, aluOut, storeData, dst, regsWr, wbSel, cp0Addr, excIn
    );
endinterface

interface cp0ExcIf;
    import memStagePkg::*;

    // CP0 state seen by the exception logic
    logic        statusBev;
    logic [7:0]  statusIm;
    logic        statusExl;
    logic        statusIe;
    logic [7:0]  causeIp;
    logic [31:0] epc;

    // commit requests back into CP0
    logic        excTake;
    excCode_e    excCode;
    logic [31:0] excPc;
    logic [31:0] badVAddr;
    logic        eretTake;

    modport cp0 (
        output statusBev, statusIm, statusExl, statusIe, causeIp, epc,
        input  excTake, excCode, excPc, badVAddr, eretTake
    );

    modport exc (
        input  statusBev, statusIm, statusExl, statusIe, causeIp, epc,
        output excTake, excCode, excPc, badVAddr, eretTake
    );
endinterface

// File: memStage.f
memStagePkg.sv
memIfs.sv
memStageReg.sv
memAccessUnit.sv
exceptionUnit.sv
cp0Regs.sv
memStageTop.sv
tbMemStage.sv

// File: memStagePkg.sv
// shared opcode, exception-code and writeback-select types plus CP0 constants for the MEM stage
package memStagePkg;

    // memory-stage opcode, decoded upstream
    typedef enum logic [3:0] {
        OP_NONE = 4'd0,
        OP_LW   = 4'd1,
        OP_LB   = 4'd2,
        OP_LBU  = 4'd3,
        OP_SW   = 4'd4,
        OP_SB   = 4'd5,
        OP_MFC0 = 4'd6,
        OP_MTC0 = 4'd7,
        OP_ERET = 4'd8
    } memOp_e;

    // Cause.ExcCode values, EXC_NONE sits on a reserved code
    typedef enum logic [4:0] {
        EXC_INT  = 5'd0,
        EXC_ADEL = 5'd4,
        EXC_ADES = 5'd5,
        EXC_SYS  = 5'd8,
        EXC_RI   = 5'd10,
        EXC_OV   = 5'd12,
        EXC_NONE = 5'd31
    } excCode_e;

    // writeback source
    typedef enum logic [1:0] {
        WB_LINK = 2'd0, // pc + 8
        WB_ALU  = 2'd1,
        WB_LOAD = 2'd2,
        WB_CP0  = 2'd3
    } wbSel_e;

    // CP0 register numbers, select 0 only
    localparam logic [4:0] CP0_BADVADDR = 5'd8;
    localparam logic [4:0] CP0_STATUS   = 5'd12;
    localparam logic [4:0] CP0_CAUSE    = 5'd13;
    localparam logic [4:0] CP0_EPC      = 5'd14;

    // handler entry points
    localparam logic [31:0] VEC_BOOT   = 32'hBFC0_0380;
    localparam logic [31:0] VEC_NORMAL = 32'h8000_0180;

endpackage

// File: memStageReg.sv
// execute-to-memory pipeline register, loaded on memWr and cleared to a bubble by memFlush
`timescale 1ns/1ps

module memStageReg (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  memFlush,
    input  logic                  memWr,
    input  memStagePkg::memOp_e   exeOp,
    input  logic [31:0]           exePc,
    input  logic [31:0]           exeAluOut,
    input  logic [31:0]           exeStoreData,
    input  logic [4:0]            exeDst,
    input  logic                  exeRegsWr,
    input  memStagePkg::wbSel_e   exeWbSel,
    input  logic [4:0]            exeCp0Addr,
    input  memStagePkg::excCode_e exeExcCode,
    memPipeIf.stage               pipe
);
    import memStagePkg::*;

    logic exeLive;

    // anything that touches memory, CP0, a register or carries a fault counts
    assign exeLive = (exeOp != OP_NONE) || exeRegsWr || (exeExcCode != EXC_NONE);

    // control part, cleared by reset and flush
    always_ff @(posedge clk) begin
        if (rst || memFlush) begin
            pipe.valid  <= 1'b0;
            pipe.regsWr <= 1'b0;
            pipe.op     <= OP_NONE;
        end else if (memWr) begin
            pipe.valid  <= exeLive;
            pipe.regsWr <= exeRegsWr;
            pipe.op     <= exeLive ? exeOp : OP_NONE;
        end
    end

    // payload, only the valid bit qualifies it
    always_ff @(posedge clk) begin
        if (memWr) begin
            pipe.pc        <= exePc;
            pipe.aluOut    <= exeAluOut;
            pipe.storeData <= exeStoreData;
            pipe.dst       <= exeDst;
            pipe.wbSel     <= exeWbSel;
            pipe.cp0Addr   <= exeCp0Addr;
            pipe.excIn     <= exeExcCode;
        end
    end

    // a bubble never carries an opcode into the memory or CP0 logic
    bubbleNoOp: assert property (
        @(posedge clk) disable iff (rst)
        !pipe.valid |-> (pipe.op == OP_NONE)
    ) else $error("memStageReg: opcode %0d on an invalid slot", pipe.op);

endmodule

// File: memStageTop.sv
// MEM stage top level, joins the pipeline register, scratchpad, exception unit and CP0
`timescale 1ns/1ps

module memStageTop #(
    parameter int MEM_WORDS = 256
) (
    input  logic                  clk,
    input  logic                  rst,
    input  memStagePkg::memOp_e   exeOp,
    input  logic [31:0]           exePc,
    input  logic [31:0]           exeAluOut,
    input  logic [31:0]           exeStoreData,
    input  logic [4:0]            exeDst,
    input  logic                  exeRegsWr,
    input  memStagePkg::wbSel_e   exeWbSel,
    input  logic [4:0]            exeCp0Addr,
    input  memStagePkg::excCode_e exeExcCode,
    input  logic                  memFlush,
    input  logic                  memWr,
    input  logic                  memDisWr,
    input  logic [5:0]            interrupt,
    output logic [31:0]           memPc,
    output logic [31:0]           memResult,
    output logic [4:0]            memDst,
    output logic                  memRegsWr,
    output logic                  excFlush,
    output logic [31:0]           excVector,
    output logic [31:0]           cp0Epc
);

    memPipeIf    pipeBus ();
    cp0ExcIf     excBus ();
    logic [31:0] cp0RdData;

    assign memPc  = pipeBus.pc;  // for refetch and debug
    assign memDst = pipeBus.dst; // forwarding destination

    memStageReg uMemReg (
        .clk          (clk),
        .rst          (rst),
        .memFlush     (memFlush),
        .memWr        (memWr),
        .exeOp        (exeOp),
        .exePc        (exePc),
        .exeAluOut    (exeAluOut),
        .exeStoreData (exeStoreData),
        .exeDst       (exeDst),
        .exeRegsWr    (exeRegsWr),
        .exeWbSel     (exeWbSel),
        .exeCp0Addr   (exeCp0Addr),
        .exeExcCode   (exeExcCode),
        .pipe         (pipeBus.stage)
    );

    memAccessUnit #(
        .MEM_WORDS (MEM_WORDS)
    ) uAccess (
        .clk       (clk),
        .rst       (rst),
        .memDisWr  (memDisWr),
        .excFlush  (excFlush),
        .pipe      (pipeBus.sink),
        .cp0RdData (cp0RdData),
        .memResult (memResult)
    );

    exceptionUnit uExc (
        .pipe      (pipeBus.sink),
        .ce        (excBus.exc),
        .memDisWr  (memDisWr),
        .memRegsWr (memRegsWr),
        .excFlush  (excFlush),
        .excVector (excVector)
    );

    cp0Regs uCp0 (
        .clk       (clk),
        .rst       (rst),
        .memDisWr  (memDisWr),
        .interrupt (interrupt),
        .pipe      (pipeBus.sink),
        .ce        (excBus.cp0),
        .cp0RdData (cp0RdData),
        .cp0Epc    (cp0Epc)
    );

endmodule

// File: tbMemStage.sv
// self-checking testbench for memStageTop, issues single instructions and checks them with assertions
`timescale 1ns/1ps

module tbMemStage;
    import memStagePkg::*;

    localparam logic [31:0] BASE = 32'h1001_0000; // bits 9:2 clear, so the offset is the index

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    memOp_e      exeOp;
    logic [31:0] exePc, exeAluOut, exeStoreData;
    logic [4:0]  exeDst, exeCp0Addr;
    logic        exeRegsWr;
    wbSel_e      exeWbSel;
    excCode_e    exeExcCode;
    logic        memFlush, memWr, memDisWr;
    logic [5:0]  interrupt;
    logic [31:0] memPc, memResult, excVector, cp0Epc;
    logic [4:0]  memDst;
    logic        memRegsWr, excFlush;

    // expectations for the cycle an instruction spends in MEM
    logic        chkOn, chkRes, expRegsWr, expFlush;
    logic [31:0] expResult, expVector, expEpc, expPc;
    logic [4:0]  expDst;
    logic        wantResChk, wantFlush;
    logic [31:0] wantRes, wantVector, curPc;

    // reference state
    logic [31:0] shadowMem [256];
    logic        mBev, mExl, mIe;
    logic [7:0]  mIm;
    logic [4:0]  mCode;
    logic [31:0] mEpc, mBad;
    logic [5:0]  mIrq;

    memStageTop #(.MEM_WORDS(256)) DUT (.*);

    always #2 clk = ~clk;

    task automatic abortRun(string msg);
        $display("TEST FAIL");
        $display("%s", msg);
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic reportMismatch(string msg);
        abortRun($sformatf("Fail at %0t ns: %s", $time, msg));
    endtask

    resultOk: assert property (@(posedge clk) disable iff (rst)
        chkOn && chkRes |-> memResult == expResult)
        else reportMismatch("memResult differs from the reference");
    fieldsOk: assert property (@(posedge clk) disable iff (rst)
        chkOn |-> memRegsWr == expRegsWr && memDst == expDst && memPc == expPc)
        else reportMismatch("memRegsWr, memDst or memPc wrong");
    flushOk: assert property (@(posedge clk) disable iff (rst)
        chkOn |-> excFlush == expFlush)
        else reportMismatch("excFlush wrong");
    vectorOk: assert property (@(posedge clk) disable iff (rst)
        chkOn && expFlush |-> excVector == expVector)
        else reportMismatch("excVector wrong");
    epcOk: assert property (@(posedge clk) disable iff (rst)
        chkOn |-> cp0Epc == expEpc)
        else reportMismatch("cp0Epc differs from the reference EPC");
    idleOk: assert property (@(posedge clk) disable iff (rst)
        !chkOn |-> !excFlush && !memRegsWr)
        else reportMismatch("excFlush or memRegsWr high on a bubble");
    stallOk: assert property (@(posedge clk) disable iff (rst)
        !memWr |=> $stable(memResult) && $stable(memPc))
        else reportMismatch("outputs moved during a stall");

    function automatic logic [31:0] handlerVec();
        return mBev ? VEC_BOOT : VEC_NORMAL;
    endfunction

    // MIPS register layouts
    function automatic logic [31:0] readCp0(logic [4:0] cpa);
        case (cpa)
            CP0_STATUS:   return {9'd0, mBev, 6'd0, mIm, 6'd0, mExl, mIe};
            CP0_CAUSE:    return {16'd0, mIrq, 2'b00, 1'b0, mCode, 2'b00};
            CP0_EPC:      return mEpc;
            CP0_BADVADDR: return mBad;
            default:      return 32'd0;
        endcase
    endfunction

    task automatic takeExc(excCode_e code, logic [31:0] pc, logic [31:0] addr);
        mExl  = 1'b1;
        mCode = code;
        mEpc  = pc;
        if (code == EXC_ADEL || code == EXC_ADES) begin
            mBad = addr;
        end
    endtask

    // one instruction with memWr high, then a bubble; checks armed for its MEM cycle
    task automatic issue(memOp_e op, logic [31:0] addr, logic [31:0] data, logic rw,
                         wbSel_e sel, logic [4:0] cpa, excCode_e exc, logic flushIn);
        logic [4:0] dst;
        dst = 5'($urandom_range(1, 31));
        @(posedge clk);
        exeOp        <= op;
        exePc        <= curPc;
        exeAluOut    <= addr;
        exeStoreData <= data;
        exeDst       <= dst;
        exeRegsWr    <= rw;
        exeWbSel     <= sel;
        exeCp0Addr   <= cpa;
        exeExcCode   <= exc;
        memFlush     <= flushIn;
        @(posedge clk);
        exeOp      <= OP_NONE; // bubble behind it
        exeRegsWr  <= 1'b0;
        exeExcCode <= EXC_NONE;
        memFlush   <= 1'b0;
        chkOn      <= 1'b1;
        chkRes     <= wantResChk;
        expResult  <= wantRes;
        expRegsWr  <= rw && !wantFlush && !flushIn;
        expDst     <= dst;
        expPc      <= curPc;
        expFlush   <= wantFlush;
        expVector  <= wantVector;
        expEpc     <= mEpc;
        @(posedge clk); // checked here and commits land on this edge
        chkOn <= 1'b0;
        curPc += 4;
    endtask

    task automatic memOp(memOp_e op, logic [31:0] addr);
        logic [31:0] pc;
        logic [31:0] data;
        logic [31:0] word;
        logic [7:0]  lane;
        logic        isStore;
        logic        bad;
        pc      = curPc;
        data    = $urandom;
        word    = shadowMem[addr[9:2]];
        lane    = word[8*addr[1:0] +: 8];
        isStore = (op == OP_SW) || (op == OP_SB);
        bad     = (op == OP_SW || op == OP_LW) && (addr[1:0] != 2'b00);
        case (op)
            OP_LB:   wantRes = {{24{lane[7]}}, lane};
            OP_LBU:  wantRes = {24'd0, lane};
            OP_LW:   wantRes = word;
            default: wantRes = addr; // stores show the address on WB_ALU
        endcase
        wantResChk = isStore || !bad;
        wantFlush  = bad;
        wantVector = handlerVec();
        issue(op, addr, data, isStore ? 1'b0 : 1'($urandom_range(0, 1)),
              isStore ? WB_ALU : WB_LOAD, 5'd0, EXC_NONE, 1'b0);
        if (bad) begin
            takeExc(isStore ? EXC_ADES : EXC_ADEL, pc, addr);
        end else if (op == OP_SW) begin
            shadowMem[addr[9:2]] = data;
        end else if (op == OP_SB) begin
            shadowMem[addr[9:2]][8*addr[1:0] +: 8] = data[7:0];
        end
    endtask

    task automatic aluOp(excCode_e exc, logic intTaken);
        logic [31:0] pc;
        logic [31:0] val;
        logic        link;
        pc   = curPc;
        val  = $urandom;
        link = 1'($urandom_range(0, 1));
        wantRes    = link ? pc + 32'd8 : val;
        wantResChk = 1'b1;
        wantFlush  = intTaken || (exc != EXC_NONE);
        wantVector = handlerVec();
        issue(OP_NONE, val, 32'd0, 1'b1, link ? WB_LINK : WB_ALU, 5'd0, exc, 1'b0);
        if (intTaken) begin
            takeExc(EXC_INT, pc, val);
        end else if (exc != EXC_NONE) begin
            takeExc(exc, pc, val);
        end
    endtask

    // MTC0, MFC0 or ERET
    task automatic cp0Op(memOp_e op, logic [4:0] cpa, logic [31:0] data);
        wantRes    = readCp0(cpa);
        wantResChk = (op == OP_MFC0);
        wantFlush  = (op == OP_ERET);
        wantVector = mEpc;
        issue(op, 32'd0, data, op == OP_MFC0, WB_CP0, cpa, EXC_NONE, 1'b0);
        if (op == OP_ERET) begin
            mExl = 1'b0;
        end else if (op == OP_MTC0 && cpa == CP0_STATUS) begin
            mBev = data[22];
            mIm  = data[15:8];
            mIe  = data[0];
        end
    endtask

    task automatic readFaultRegs();
        cp0Op(OP_MFC0, CP0_CAUSE, 32'd0);
        cp0Op(OP_MFC0, CP0_EPC, 32'd0);
        cp0Op(OP_MFC0, CP0_BADVADDR, 32'd0);
        cp0Op(OP_ERET, 5'd0, 32'd0);
    endtask

    task automatic setIrq(logic [5:0] lines);
        @(posedge clk);
        interrupt <= lines;
        mIrq = lines;
    endtask

    // store held by memWr low with memDisWr high and then released
    task automatic stallStore(logic [31:0] addr);
        logic [31:0] data;
        data = shadowMem[addr[9:2]] ^ ($urandom | 32'h1); // always differs from the old word
        @(posedge clk);
        exeOp        <= OP_SW;
        exePc        <= curPc;
        exeAluOut    <= addr;
        exeStoreData <= data;
        exeWbSel     <= WB_LOAD; // old word stays visible on memResult while held
        memDisWr     <= 1'b1;
        @(posedge clk);
        exeOp <= OP_NONE;
        memWr <= 1'b0; // hold it in MEM
        repeat (3) @(posedge clk);
        memDisWr <= 1'b0;
        memWr    <= 1'b1; // commits and leaves on the same edge
        @(posedge clk);
        shadowMem[addr[9:2]] = data;
        curPc += 4;
    endtask

    task automatic waitIdle(int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (excFlush || memRegsWr) begin
            n++;
            if (n > limit) begin
                abortRun("timed out waiting for excFlush and memRegsWr to drop after reset");
            end
            @(negedge clk);
        end
    endtask

    initial begin
        int         idx;
        int         line;
        logic [7:0] im;
        void'($urandom(54279));
        exeOp        = OP_NONE;
        exePc        = '0;
        exeAluOut    = '0;
        exeStoreData = '0;
        exeDst       = '0;
        exeRegsWr    = 1'b0;
        exeWbSel     = WB_ALU;
        exeCp0Addr   = '0;
        exeExcCode   = EXC_NONE;
        memFlush     = 1'b0;
        memWr        = 1'b1;
        memDisWr     = 1'b0;
        interrupt    = '0;
        chkOn        = 1'b0;
        wantResChk   = 1'b0;
        wantFlush    = 1'b0;
        curPc        = 32'hBFC0_0000;
        mBev         = 1'b1; // reset state of Status
        mExl         = 1'b0;
        mIe          = 1'b0;
        mIm          = '0;
        mCode        = '0;
        mEpc         = '0;
        mBad         = '0;
        mIrq         = '0;
        foreach (shadowMem[i]) begin
            shadowMem[i] = '0;
        end

        repeat (10) @(posedge clk);
        rst <= 1'b0;
        waitIdle(4);

        // word and byte traffic over the first 16 words
        for (int i = 0; i < 20; i++) begin
            idx = $urandom_range(0, 15);
            memOp(OP_SW, BASE + 32'(idx * 4));
            memOp(OP_SB, BASE + 32'(idx * 4 + $urandom_range(0, 3)));
            memOp(OP_LW, BASE + 32'(idx * 4));
            memOp(OP_LB, BASE + 32'($urandom_range(0, 63)));
            memOp(OP_LBU, BASE + 32'($urandom_range(0, 63)));
        end

        for (int i = 0; i < 4; i++) begin
            im = 8'($urandom);
            cp0Op(OP_MTC0, CP0_STATUS, {9'd0, 1'($urandom_range(0, 1)), 6'd0, im, 7'd0,
                                        1'($urandom_range(0, 1))});
            cp0Op(OP_MFC0, CP0_STATUS, 32'd0);
        end
        cp0Op(OP_MTC0, CP0_STATUS, 32'h0040_0000); // IE off, BEV on
        setIrq(6'($urandom_range(1, 63)));
        cp0Op(OP_MFC0, CP0_CAUSE, 32'd0);
        setIrq(6'd0);

        // address errors with the boot vector first
        memOp(OP_LW, BASE + 32'h0000_0041);
        readFaultRegs();
        cp0Op(OP_MTC0, CP0_STATUS, 32'd0);
        memOp(OP_SW, BASE + 32'h0000_0022);
        memOp(OP_LW, BASE + 32'h0000_0020); // word untouched by the faulting store
        readFaultRegs();

        line = $urandom_range(0, 5);
        cp0Op(OP_MTC0, CP0_STATUS, (32'h0000_0400 << line) | 32'h1);
        setIrq(6'd1 << line);
        aluOp(EXC_NONE, 1'b1);
        aluOp(EXC_NONE, 1'b0); // masked while EXL is set
        aluOp(EXC_SYS, 1'b0);
        cp0Op(OP_MFC0, CP0_EPC, 32'd0);
        cp0Op(OP_MFC0, CP0_CAUSE, 32'd0);
        cp0Op(OP_ERET, 5'd0, 32'd0);
        aluOp(EXC_NONE, 1'b1); // still pending after ERET
        setIrq(6'd0);
        cp0Op(OP_ERET, 5'd0, 32'd0);
        cp0Op(OP_MTC0, CP0_STATUS, 32'd0);

        // flushed on entry, so no write and no trap
        wantResChk = 1'b0;
        wantFlush  = 1'b0;
        issue(OP_SW, BASE + 32'h0000_0030, 32'hDEAD_BEEF, 1'b0, WB_ALU, 5'd0, EXC_NONE, 1'b1);
        issue(OP_NONE, 32'd0, 32'd0, 1'b1, WB_ALU, 5'd0, EXC_SYS, 1'b1);
        memOp(OP_LW, BASE + 32'h0000_0030);
        stallStore(BASE + 32'h0000_0040);
        memOp(OP_LW, BASE + 32'h0000_0040);

        $display("TEST PASS");
        $finish;
    end

endmodule
